// ==== Makefile ====
# Verilator build and run for the flag unit testbench

VERILATOR ?= verilator
TOP       ?= flag_unit_tb
FLIST     ?= flag_unit.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --timescale 1ns/1ps

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "variables: VERILATOR TOP FLIST OBJ_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FLIST)
	@out=$$(./$(OBJ_DIR)/V$(TOP) 2>&1); \
	echo "$$out"; \
	if echo "$$out" | grep -q "All checks passed"; then \
		echo "simulation passed"; \
	else \
		echo "simulation failed"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR)

// ==== bench/flag_unit_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module flag_unit_tb;

    import flag_unit_pkg::*;

    localparam int clk_period = 100;
    localparam int n_arith    = 200;    // adc/sbc pairs
    localparam int n_logic    = 30;     // per logic op, lda and cmp
    localparam int n_plp      = 20;
    localparam int n_nop      = 8;
    localparam int n_hs       = 12;
    // every exchange of the run including flag setup
    localparam int total_ops  = 2 * n_arith + 5 * n_logic + 2 + 9 + n_plp + n_nop + n_hs;

    logic            clk;
    logic            nrst;
    logic            req;
    logic [op_w-1:0] op;
    logic [7:0]      a;
    logic [7:0]      b;
    logic            brk;
    logic            ack;
    logic [7:0]      result;
    logic [7:0]      psr;

    psr_word_t   exp_psr;      // stored flags with break bits kept 0
    logic [7:0]  exp_result;
    int unsigned seed_val;

    flag_unit dut_i (
        .clk, .nrst, .req, .op, .a, .b, .brk,
        .ack, .result, .psr
    );

    always #(clk_period / 2) clk = ~clk;

    initial begin
        #((total_ops * 10 + 16) * clk_period);
        $display("timeout: the DUT stopped answering requests");
        $display("Checks failed");
        $fatal(1, "watchdog expired");
    end

    // what the port should show for a stored word
    function automatic psr_word_t shown_psr(input psr_word_t stored, input logic brk_v);
        psr_word_t w;
        w           = stored;
        w.flag.b_hi = brk_v;
        w.flag.b_lo = brk_v;
        return w;
    endfunction

    task automatic check_result(input logic [7:0] expected, input logic [7:0] actual,
                                input string what);
        if (actual !== expected) begin
            $display("ERR %0t: %s result expected %02h actual %02h",
                     $time, what, expected, actual);
            $display("Checks failed");
            $fatal(1, "result mismatch");
        end
    endtask

    task automatic check_psr(input psr_word_t expected, input psr_word_t actual,
                             input string what);
        if (actual.raw !== expected.raw) begin
            $display("ERR %0t: %s psr (nvbbdizc) expected %08b actual %08b",
                     $time, what, expected.raw, actual.raw);
            $display("Checks failed");
            $fatal(1, "psr mismatch");
        end
    endtask

    task automatic check_ack(input logic expected, input logic actual, input string what);
        if (actual !== expected) begin
            $display("ERR %0t: %s ack expected %b actual %b", $time, what, expected, actual);
            $display("Checks failed");
            $fatal(1, "ack mismatch");
        end
    endtask

    // reference model for the binary 6502 rules
    task automatic model_op(input logic [op_w-1:0] code, input logic [7:0] av,
                            input logic [7:0] bv);
        logic [8:0] s;
        logic [7:0] bb;
        bb         = (code == op_sbc) ? ~bv : bv;
        exp_result = av;                    // flag ops and no-op pass a
        case (code)
            op_adc, op_sbc: begin
                s              = {1'b0, av} + {1'b0, bb} + {8'd0, exp_psr.flag.c};
                exp_result     = s[7:0];
                exp_psr.flag.c = s[8];
                exp_psr.flag.v = (av[7] ^ s[7]) & (bb[7] ^ s[7]);   // sign flip on like signs
            end
            op_cmp: begin
                exp_result     = av - bv;
                exp_psr.flag.c = (av >= bv);
            end
            op_and: exp_result = av & bv;
            op_ora: exp_result = av | bv;
            op_eor: exp_result = av ^ bv;
            op_lda, op_plp: exp_result = bv;
            op_sec: exp_psr.flag.c = 1'b1;
            op_clc: exp_psr.flag.c = 1'b0;
            op_sei: exp_psr.flag.i = 1'b1;
            op_cli: exp_psr.flag.i = 1'b0;
            op_sed: exp_psr.flag.d = 1'b1;
            op_cld: exp_psr.flag.d = 1'b0;
            op_clv: exp_psr.flag.v = 1'b0;
            default: ;
        endcase
        if (code <= op_lda) begin           // n and z follow the byte
            exp_psr.flag.n = exp_result[7];
            exp_psr.flag.z = (exp_result == 8'd0);
        end
        if (code == op_plp) begin
            exp_psr.flag.n = bv[7];
            exp_psr.flag.v = bv[6];
            exp_psr.flag.d = bv[3];
            exp_psr.flag.i = bv[2];
            exp_psr.flag.z = bv[1];
            exp_psr.flag.c = bv[0];
        end
    endtask

    // one full four-phase exchange
    task automatic do_op(input logic [op_w-1:0] code, input logic [7:0] av,
                         input logic [7:0] bv);
        @(posedge clk);
        req <= 1'b1;
        op  <= code;
        a   <= av;
        b   <= bv;
        @(negedge clk);
        while (ack !== 1'b1) @(negedge clk);
        @(posedge clk);
        req <= 1'b0;
        @(negedge clk);
        while (ack !== 1'b0) @(negedge clk);
    endtask

    task automatic run_checked(input logic [op_w-1:0] code, input logic [7:0] av,
                               input logic [7:0] bv, input string what);
        model_op(code, av, bv);
        do_op(code, av, bv);
        check_result(exp_result, result, what);
        check_psr(shown_psr(exp_psr, brk), psr, what);
    endtask

    task automatic test_reset_state();
        @(negedge clk);
        check_ack(1'b0, ack, "after reset");
        check_result(8'd0, result, "after reset");
        check_psr(shown_psr(exp_psr, 1'b0), psr, "after reset");
        @(posedge clk);
        brk <= 1'b1;
        @(negedge clk);
        check_psr(shown_psr(exp_psr, 1'b1), psr, "brk high");   // bits 5:4 only
        @(posedge clk);
        brk <= 1'b0;
        @(negedge clk);
        check_psr(shown_psr(exp_psr, 1'b0), psr, "brk low");
    endtask

    task automatic test_add_sub();
        logic [op_w-1:0] code;
        for (int k = 0; k < n_arith; k++) begin
            if (k == n_arith / 2) begin     // i and d flip for the second half
                run_checked(op_plp, 8'($urandom), exp_psr.raw ^ 8'h0c, "i/d flip");
            end
            run_checked(1'($urandom) ? op_sec : op_clc, 8'($urandom), 8'($urandom), "sec/clc");
            code = 1'($urandom) ? op_sbc : op_adc;
            run_checked(code, 8'($urandom), 8'($urandom), "adc/sbc");
        end
    endtask

    task automatic test_logic_ops();
        for (int k = 0; k < n_logic; k++) begin
            if (k == n_logic / 2) begin     // v flips halfway
                run_checked(op_plp, 8'($urandom), exp_psr.raw ^ 8'h40, "v flip");
            end
            run_checked(op_and, 8'($urandom), 8'($urandom), "and");
            run_checked(op_ora, 8'($urandom), 8'($urandom), "ora");
            run_checked(op_eor, 8'($urandom), 8'($urandom), "eor");
            run_checked(op_lda, 8'($urandom), 8'($urandom), "lda");
            run_checked(op_cmp, 8'($urandom), 8'($urandom), "cmp");
        end
    endtask

    task automatic test_flag_ops();
        run_checked(op_plp, 8'($urandom), 8'h00, "plp clear");
        run_checked(op_sec, 8'($urandom), 8'($urandom), "sec");
        run_checked(op_sei, 8'($urandom), 8'($urandom), "sei");
        run_checked(op_sed, 8'($urandom), 8'($urandom), "sed");
        run_checked(op_clc, 8'($urandom), 8'($urandom), "clc");
        run_checked(op_cli, 8'($urandom), 8'($urandom), "cli");
        run_checked(op_cld, 8'($urandom), 8'($urandom), "cld");
        run_checked(op_plp, 8'($urandom), 8'hff, "plp set");     // v up for clv
        run_checked(op_clv, 8'($urandom), 8'($urandom), "clv");
        for (int k = 0; k < n_plp; k++) begin
            @(posedge clk);
            brk <= 1'($urandom);            // break bits must ignore b
            run_checked(op_plp, 8'($urandom), 8'($urandom), "plp");
        end
        for (int k = 0; k < n_nop; k++) begin
            run_checked(4'd15, 8'($urandom), 8'($urandom), "no-op");
        end
        @(posedge clk);
        brk <= 1'b0;
    endtask

    task automatic test_handshake();
        logic [op_w-1:0] code;
        logic [7:0]      av;
        logic [7:0]      bv;
        int              hold;
        for (int k = 0; k < n_hs; k++) begin
            code = 4'($urandom);
            av   = 8'($urandom);
            bv   = 8'($urandom);
            hold = $urandom_range(8, 1);
            model_op(code, av, bv);
            @(posedge clk);
            req <= 1'b1;
            op  <= code;
            a   <= av;
            b   <= bv;
            @(negedge clk);
            check_ack(1'b0, ack, "before first edge");
            @(negedge clk);
            check_ack(1'b0, ack, "after first edge");   // accepted and now in exec
            @(negedge clk);
            check_ack(1'b1, ack, "after second edge");
            check_result(exp_result, result, "handshake");
            check_psr(shown_psr(exp_psr, brk), psr, "handshake");
            repeat (hold) begin             // back-pressure so nothing moves
                @(negedge clk);
                check_ack(1'b1, ack, "req held");
                check_result(exp_result, result, "req held");
                check_psr(shown_psr(exp_psr, brk), psr, "req held");
            end
            @(posedge clk);
            req <= 1'b0;
            @(negedge clk);
            check_ack(1'b1, ack, "req low not yet sampled");
            @(negedge clk);
            check_ack(1'b0, ack, "req low sampled");
        end
    endtask

    initial begin
        seed_val   = $urandom(15);
        clk        = 1'b0;
        nrst       = 1'b0;
        req        = 1'b0;
        op         = '1;                    // no-op code
        a          = 8'd0;
        b          = 8'd0;
        brk        = 1'b0;
        exp_psr    = '0;
        exp_result = 8'd0;
        repeat (16) @(posedge clk);
        nrst <= 1'b1;
        test_reset_state();
        test_add_sub();
        test_logic_ops();
        test_flag_ops();
        test_handshake();
        $display("All checks passed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== flag_unit.f ====
hdl/flag_unit_pkg.sv
hdl/alu_core.sv
hdl/flag_control.sv
hdl/status_reg.sv
hdl/flag_unit.sv
bench/flag_unit_tb.sv

// ==== hdl/alu_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module alu_core (
    input  logic                           clk,
    input  logic                           nrst,
    input  logic                           accept,     // one-cycle strobe from control
    input  logic [flag_unit_pkg::op_w-1:0] op,         // latched op from control
    input  logic [7:0]                     a,
    input  logic [7:0]                     b,
    input  logic                           carry_in,   // stored C
    output logic [7:0]                     db,         // next byte, combinational
    output logic                           carry,
    output logic                           overflow,
    output logic [7:0]                     result
);

    import flag_unit_pkg::*;

    logic [7:0] a_q;        // operand latches
    logic [7:0] b_q;
    logic       accept_q;   // high for the one exec cycle
    logic [7:0] b_in;       // adder b side, inverted for sbc/cmp
    logic       c_in;
    logic [8:0] sum;        // bit 8 is carry out of bit 7

    // operands held for the whole exchange
    always_ff @(posedge clk) begin
        if (accept) begin
            a_q <= a;
            b_q <= b;
        end
    end

    // exec follows accept by exactly one cycle
    always_ff @(posedge clk, negedge nrst) begin
        if (!nrst) begin
            accept_q <= 1'b0;
        end else begin
            accept_q <= accept;
        end
    end

    // adder input select
    always_comb begin
        b_in = b_q;
        c_in = carry_in;
        if (op == op_sbc) begin
            b_in = ~b_q;    // a + ~b + c, borrow is ~c
        end else if (op == op_cmp) begin
            b_in = ~b_q;
            c_in = 1'b1;    // plain subtract, no borrow in
        end
    end

    assign sum      = {1'b0, a_q} + {1'b0, b_in} + {8'd0, c_in};
    assign carry    = sum[8];   // for cmp: a >= b
    // same sign in, different sign out
    assign overflow = (a_q[7] == b_in[7]) && (sum[7] != a_q[7]);

    always_comb begin
        case (op)
            op_adc, op_sbc, op_cmp: db = sum[7:0];
            op_and:                 db = a_q & b_q;
            op_ora:                 db = a_q | b_q;
            op_eor:                 db = a_q ^ b_q;
            op_lda, op_plp:         db = b_q;
            default:                db = a_q;   // flag ops and no-op
        endcase
    end

    // result lands with the flag update, on the edge leaving exec
    always_ff @(posedge clk, negedge nrst) begin
        if (!nrst) begin
            result <= 8'd0;
        end else if (accept_q) begin
            result <= db;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/flag_control.sv ====
`timescale 1ns/1ps
`default_nettype none

module flag_control (
    input  logic                           clk,
    input  logic                           nrst,
    input  logic                           req,
    input  logic [flag_unit_pkg::op_w-1:0] op,
    output logic                           ack,
    output logic                           accept,
    output logic [flag_unit_pkg::op_w-1:0] op_q,
    output logic                           db0_c,
    output logic                           db1_z,
    output logic                           db2_i,
    output logic                           db3_d,
    output logic                           db6_v,
    output logic                           db7_n,
    output logic                           dball_z,     // z from nor of db
    output logic                           carry_c,     // c from alu
    output logic                           overflow_v,  // v from alu
    output logic                           manual_c,
    output logic                           manual_i,
    output logic                           manual_d,
    output logic                           clear_v,
    output logic                           manual_set   // value for the manual writes
);

    import flag_unit_pkg::*;

    localparam logic [1:0] st_idle = 2'd0;
    localparam logic [1:0] st_exec = 2'd1;
    localparam logic [1:0] st_done = 2'd2;   // ack held here

    logic [1:0] state;
    logic [1:0] state_nxt;

    assign accept = (state == st_idle) && req;   // ack is low whenever idle
    assign ack    = (state == st_done);

    always_comb begin
        state_nxt = state;
        case (state)
            st_idle: if (req) state_nxt = st_exec;
            st_exec: state_nxt = st_done;            // single exec cycle
            st_done: if (!req) state_nxt = st_idle;  // wait for req low
            default: state_nxt = st_idle;
        endcase
    end

    always_ff @(posedge clk, negedge nrst) begin
        if (!nrst) begin
            state <= st_idle;
            op_q  <= '1;                    // no-op code
        end else begin
            state <= state_nxt;
            if (accept) op_q <= op;
        end
    end

    // decode, only while in exec
    always_comb begin
        db0_c      = 1'b0;
        db1_z      = 1'b0;
        db2_i      = 1'b0;
        db3_d      = 1'b0;
        db6_v      = 1'b0;
        db7_n      = 1'b0;
        dball_z    = 1'b0;
        carry_c    = 1'b0;
        overflow_v = 1'b0;
        manual_c   = 1'b0;
        manual_i   = 1'b0;
        manual_d   = 1'b0;
        clear_v    = 1'b0;
        manual_set = 1'b0;
        if (state == st_exec) begin
            case (op_q)
                op_adc, op_sbc: begin
                    {dball_z, db7_n, carry_c, overflow_v} = 4'b1111;
                end
                op_cmp: {dball_z, db7_n, carry_c} = 3'b111;    // v untouched
                op_and, op_ora, op_eor, op_lda: {dball_z, db7_n} = 2'b11;
                op_plp: {db0_c, db1_z, db2_i, db3_d, db6_v, db7_n} = 6'b111111;
                op_sec: {manual_c, manual_set} = 2'b11;
                op_clc: manual_c = 1'b1;
                op_sei: {manual_i, manual_set} = 2'b11;
                op_cli: manual_i = 1'b1;
                op_sed: {manual_d, manual_set} = 2'b11;
                op_cld: manual_d = 1'b1;
                op_clv: clear_v = 1'b1;
                default: ;                  // no-op, nothing written
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== hdl/flag_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module flag_unit (
    input  logic                           clk,
    input  logic                           nrst,
    input  logic                           req,
    input  logic [flag_unit_pkg::op_w-1:0] op,
    input  logic [7:0]                     a,
    input  logic [7:0]                     b,
    input  logic                           brk,
    output logic                           ack,
    output logic [7:0]                     result,
    output logic [7:0]                     psr
);

    import flag_unit_pkg::*;

    logic            accept;
    logic [op_w-1:0] op_q;       // op held by control for the alu
    logic [7:0]      db;
    logic            carry;
    logic            overflow;
    // flag write enables, one cycle in exec
    logic db0_c, db1_z, db2_i, db3_d, db6_v, db7_n;
    logic dball_z, carry_c, overflow_v;
    logic manual_c, manual_i, manual_d, clear_v, manual_set;

    flag_control control_i (
        .clk, .nrst, .req, .op, .ack, .accept, .op_q,
        .db0_c, .db1_z, .db2_i, .db3_d, .db6_v, .db7_n,
        .dball_z, .carry_c, .overflow_v,
        .manual_c, .manual_i, .manual_d, .clear_v, .manual_set
    );

    alu_core alu_i (
        .clk, .nrst, .accept,
        .op       (op_q),
        .a, .b,
        .carry_in (psr[0]),     // stored C feeds adc/sbc
        .db, .carry, .overflow, .result
    );

    status_reg status_i (
        .clk, .nrst, .db, .carry, .overflow, .brk,
        .db0_c, .db1_z, .db2_i, .db3_d, .db6_v, .db7_n,
        .dball_z, .carry_c, .overflow_v,
        .manual_c, .manual_i, .manual_d, .clear_v, .manual_set,
        .psr
    );

endmodule

`default_nettype wire

// ==== hdl/flag_unit_pkg.sv ====
`default_nettype none

package flag_unit_pkg;

    localparam int op_w = 4;        // opcode width from the sequencer

    // arithmetic, binary only
    localparam logic [op_w-1:0] op_adc = 4'd0;
    localparam logic [op_w-1:0] op_sbc = 4'd1;
    // logic ops on a and b
    localparam logic [op_w-1:0] op_and = 4'd2;
    localparam logic [op_w-1:0] op_ora = 4'd3;
    localparam logic [op_w-1:0] op_eor = 4'd4;
    localparam logic [op_w-1:0] op_cmp = 4'd5;   // a - b, result kept
    localparam logic [op_w-1:0] op_lda = 4'd6;   // pass b
    localparam logic [op_w-1:0] op_plp = 4'd7;   // flags from b
    // single flag set / clear
    localparam logic [op_w-1:0] op_sec = 4'd8;
    localparam logic [op_w-1:0] op_clc = 4'd9;
    localparam logic [op_w-1:0] op_sei = 4'd10;
    localparam logic [op_w-1:0] op_cli = 4'd11;
    localparam logic [op_w-1:0] op_sed = 4'd12;
    localparam logic [op_w-1:0] op_cld = 4'd13;
    localparam logic [op_w-1:0] op_clv = 4'd14;
    // code 15 is the no-op, returns a and touches no flag

    // status word, bit 7 down to bit 0
    typedef struct packed {
        logic n;        // negative
        logic v;        // overflow
        logic b_hi;     // break, bit 5
        logic b_lo;     // break, bit 4
        logic d;        // decimal, stored only
        logic i;        // irq disable
        logic z;        // zero
        logic c;        // carry
    } psr_flags_t;

    // raw byte for the port and for plp, flag view for per-bit updates
    typedef union packed {
        logic [7:0] raw;
        psr_flags_t flag;
    } psr_word_t;

endpackage

`default_nettype wire

// ==== hdl/status_reg.sv ====
`timescale 1ns/1ps
`default_nettype none

module status_reg (
    input  logic       clk,
    input  logic       nrst,
    input  logic [7:0] db,          // next byte from alu
    input  logic       carry,
    input  logic       overflow,
    input  logic       brk,         // break level, shown on bits 5:4
    input  logic       db0_c,
    input  logic       db1_z,
    input  logic       db2_i,
    input  logic       db3_d,
    input  logic       db6_v,
    input  logic       db7_n,
    input  logic       dball_z,
    input  logic       carry_c,
    input  logic       overflow_v,
    input  logic       manual_c,
    input  logic       manual_i,
    input  logic       manual_d,
    input  logic       clear_v,
    input  logic       manual_set,
    output logic [7:0] psr
);

    import flag_unit_pkg::*;

    psr_word_t flags_q;     // stored flags, break bits stay 0
    psr_word_t flags_d;
    psr_word_t psr_w;

    // later writes win
    always_comb begin
        flags_d = flags_q;              // hold by default
        if (db0_c) flags_d.flag.c = db[0];
        if (db1_z) flags_d.flag.z = db[1];
        if (db2_i) flags_d.flag.i = db[2];
        if (db3_d) flags_d.flag.d = db[3];
        if (db6_v) flags_d.flag.v = db[6];
        if (db7_n) flags_d.flag.n = db[7];
        if (dball_z) flags_d.flag.z = ~|db;
        if (manual_c) flags_d.flag.c = manual_set;
        if (manual_i) flags_d.flag.i = manual_set;
        if (manual_d) flags_d.flag.d = manual_set;
        if (carry_c) flags_d.flag.c = carry;
        if (overflow_v) flags_d.flag.v = overflow;
        if (clear_v) flags_d.flag.v = 1'b0;
    end

    always_ff @(posedge clk, negedge nrst) begin
        if (!nrst) begin
            flags_q <= '0;
        end else begin
            flags_q <= flags_d;
        end
    end

    // break bits come straight from the pin
    always_comb begin
        psr_w           = flags_q;
        psr_w.flag.b_hi = brk;
        psr_w.flag.b_lo = brk;
    end

    assign psr = psr_w.raw;

endmodule

`default_nettype wire
